//--- verification/periph_stim.txt
# name op addr wdata exp_rdata exp_pslverr has_byte exp_byte
# op is rd or wr; addr, data and byte in hex, the two flags 0 or 1
rom_w0      rd 00000000 00000000 00001197 0 0 00
rom_w1      rd 00000004 00000000 80018193 0 0 00
rom_w3      rd 0000000c 00000000 ff810113 0 0 00
rom_w6      rd 00000018 00000000 0062a023 0 0 00
rom_tag     rd 00000020 00000000 44485342 0 0 00
rom_ver     rd 00000024 00000000 00000001 0 0 00
rom_blank   rd 000000a0 00000000 00000000 0 0 00
rom_wr      wr 00000008 deadbeef 00000000 1 0 00
rom_rdbk    rd 00000008 00000000 00002117 0 0 00
gap_rd      rd 00000800 00000000 00000000 1 0 00
gap_wr      wr 00002000 12345678 00000000 1 0 00
high_rd     rd 80001000 00000000 00000000 1 0 00
uart_ofs_rd rd 0000100c 00000000 00000000 1 0 00
uart_ofs_wr wr 0000100c 00000055 00000000 1 0 00
div_rst     rd 00001008 00000000 00000010 0 0 00
div_wr      wr 00001008 abcd0008 00000000 0 0 00
div_rdbk    rd 00001008 00000000 00000008 0 0 00
stat_idle   rd 00001004 00000000 00000000 0 0 00
tx_first    wr 00001000 000000a5 00000000 0 1 a5
tx_pair_a   wr 00001000 0000013c 00000000 0 1 3c
stat_busy   rd 00001004 00000000 00000001 0 0 00
tx_pair_b   wr 00001000 000000c3 00000000 0 1 c3

//--- periph_subsystem.f
+incdir+include
logic/dhs_periph_pkg.sv
logic/apb_wb_bridge.sv
logic/periph_link.sv
logic/boot_rom.sv
logic/uart_tx.sv
logic/periph_subsystem.sv
verification/periph_subsystem_assert.sv
verification/periph_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := periph_subsystem_tb
FILELIST  := periph_subsystem.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) include/boot_rom_table.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/periph_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_tb;

  import dhs_periph_pkg::*;

  localparam int unsigned ROM_WORDS = 64;
  localparam int unsigned DIV_RESET = 16;
  localparam addr_t UART_DIV_ADDR = UART_BASE + 32'(UART_DIV_OFS);

  // One line of the stimulus file
  typedef struct packed {
    logic [127:0] name;
    logic         is_write;
    addr_t        addr;
    data_t        wdata;
    data_t        rdata;
    logic         err;
    logic         has_byte;
    uart_byte_t   tx_byte;
  } stim_t;

  logic        clk = 1'b0;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        uart_tx;

  stim_t        stim_q[$];
  uart_byte_t   exp_bytes[$];
  logic [127:0] exp_names[$];
  uart_byte_t   rx_bytes[$];
  div_t         cur_div = div_t'(DIV_RESET);
  int unsigned  stops_seen = 0;
  int unsigned  cycle_cnt = 0;
  int unsigned  cycle_limit = 0;
  logic [31:0]  rng_state = 32'hf10747cd;

  periph_subsystem #(
    .ROM_WORDS(ROM_WORDS),
    .DIV_RESET(DIV_RESET)
  ) dut0 (
    .periphl_clk_i(clk),
    .arst_n_i     (arst_n),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp),
    .uart_tx_o    (uart_tx)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input logic [127:0] test_name, input data_t exp_val,
                            input data_t act_val);
    if (act_val !== exp_val) begin
      $display("Error %0s: expected %h, actual %h", test_name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  task automatic check_err(input logic [127:0] test_name, input logic exp_val,
                           input logic act_val);
    if (act_val !== exp_val) begin
      $display("Error %0s: expected pslverr %b, actual %b", test_name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  task automatic check_byte(input logic [127:0] test_name, input uart_byte_t exp_val,
                            input uart_byte_t act_val);
    if (act_val !== exp_val) begin
      $display("Error %0s: expected serial byte %h, actual %h", test_name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  // Setup cycle, then access cycles until pready
  task automatic run_transfer(input stim_t s, output data_t rdata, output logic slverr);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= s.is_write;
    apb_req.paddr   <= s.addr;
    apb_req.pwdata  <= s.wdata;
    apb_req.pstrb   <= '1;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // Serial decoder
  ////////////////////////////////////////////////////////////

  initial begin : serial_decoder
    uart_byte_t rx;
    div_t       bit_div;
    rx = '0;
    forever begin
      @(negedge clk);
      if (arst_n === 1'b1 && uart_tx === 1'b0) begin
        bit_div = cur_div;
        // Middle of the start bit
        repeat (bit_div / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          $display("Start bit on uart_tx_o did not stay low to its middle");
          stop_on_failure();
        end
        repeat (8) begin
          repeat (bit_div) @(negedge clk);
          rx = {uart_tx, rx[7:1]};
        end
        repeat (bit_div) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          $display("Stop bit on uart_tx_o was low after byte %h", rx);
          stop_on_failure();
        end
        stops_seen = stops_seen + 1;
        rx_bytes.push_back(rx);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_sequence
    int           fd;
    int           nf;
    string        line;
    logic [127:0] f_name;
    logic [15:0]  f_op;
    logic [31:0]  f_addr;
    logic [31:0]  f_wdata;
    logic [31:0]  f_rdata;
    logic [31:0]  f_err;
    logic [31:0]  f_has;
    logic [31:0]  f_byte;
    stim_t        s;
    int unsigned  max_div;
    int unsigned  tx_writes;
    data_t        rdata;
    logic         slverr;

    arst_n  = 1'b0;
    apb_req = '0;
    max_div = DIV_RESET;
    fd = $fopen("verification/periph_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/periph_stim.txt");
      stop_on_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      nf = $sscanf(line, "%s %s %h %h %h %d %d %h", f_name, f_op, f_addr, f_wdata,
                   f_rdata, f_err, f_has, f_byte);
      if (nf != 8) begin
        $display("Malformed stimulus line: %s", line);
        stop_on_failure();
      end
      s.name     = f_name;
      s.is_write = (f_op == "wr");
      s.addr     = f_addr;
      s.wdata    = f_wdata;
      s.rdata    = f_rdata;
      s.err      = f_err[0];
      s.has_byte = f_has[0];
      s.tx_byte  = f_byte[7:0];
      if (s.is_write && !s.err && s.addr == UART_DIV_ADDR &&
          32'(s.wdata[15:0]) > max_div) begin
        max_div = 32'(s.wdata[15:0]);
      end
      stim_q.push_back(s);
    end
    $fclose(fd);
    cycle_limit = stim_q.size() * (10 * max_div + 20);

    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    tx_writes = 0;
    foreach (stim_q[n]) begin
      s = stim_q[n];
      rng_state = xorshift32(rng_state);
      repeat (rng_state[1:0]) @(posedge clk);
      run_transfer(s, rdata, slverr);
      if (s.has_byte) begin
        // A held data write ends only after the previous stop bit
        if (stops_seen < tx_writes) begin
          $display("pready of %0s came before the previous frame's stop bit", s.name);
          stop_on_failure();
        end
        tx_writes = tx_writes + 1;
        exp_bytes.push_back(s.tx_byte);
        exp_names.push_back(s.name);
      end
      check_err(s.name, s.err, slverr);
      if (!s.is_write || s.err) check_data(s.name, s.rdata, rdata);
      if (s.is_write && !s.err && s.addr == UART_DIV_ADDR) cur_div = s.wdata[15:0];
    end

    // Let the last frame finish, then leave room for a stray one
    while (rx_bytes.size() < exp_bytes.size()) @(posedge clk);
    repeat (12 * cur_div) @(posedge clk);
    foreach (exp_bytes[k]) check_byte(exp_names[k], exp_bytes[k], rx_bytes[k]);

    if (rx_bytes.size() == exp_bytes.size()) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Serial line carried %0d frames where %0d were written",
               rx_bytes.size(), exp_bytes.size());
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- verification/periph_subsystem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem_assert (
  input logic                     periphl_clk_i,
  input logic                     arst_n_i,
  input dhs_periph_pkg::apb_rsp_t apb_rsp_o,
  input dhs_periph_pkg::wb_req_t  wb_req_o,
  input dhs_periph_pkg::wb_rsp_t  wb_rsp_i
);

  // Request stays up until the target answers
  stb_held: assert property (@(posedge periphl_clk_i) disable iff (!arst_n_i)
    wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err |=> wb_req_o.stb)
    else $error("Wishbone stb dropped before ack or err");

  ack_err_excl: assert property (@(posedge periphl_clk_i) disable iff (!arst_n_i)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else $error("Wishbone ack and err high together");

  // Single-cycle pready
  pready_pulse: assert property (@(posedge periphl_clk_i) disable iff (!arst_n_i)
    apb_rsp_o.pready |=> !apb_rsp_o.pready)
    else $error("APB pready held longer than one cycle");

endmodule

bind apb_wb_bridge periph_subsystem_assert bridge_checks (
  .periphl_clk_i(periphl_clk_i),
  .arst_n_i     (arst_n_i),
  .apb_rsp_o    (apb_rsp_o),
  .wb_req_o     (wb_req_o),
  .wb_rsp_i     (wb_rsp_i)
);

`default_nettype wire

//--- logic/periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem #(
  parameter int unsigned ROM_WORDS = 64,
  parameter int unsigned DIV_RESET = 16
) (
  input  logic                     periphl_clk_i,
  input  logic                     arst_n_i,
  input  dhs_periph_pkg::apb_req_t apb_req_i,
  output dhs_periph_pkg::apb_rsp_t apb_rsp_o,
  output logic                     uart_tx_o
);

  import dhs_periph_pkg::*;

  wb_req_t host_wb_req;
  wb_rsp_t host_wb_rsp;
  wb_req_t rom_wb_req;
  wb_rsp_t rom_wb_rsp;
  wb_req_t uart_wb_req;
  wb_rsp_t uart_wb_rsp;

  // Host side
  apb_wb_bridge apb_slave (
    .periphl_clk_i(periphl_clk_i),
    .arst_n_i     (arst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .wb_req_o     (host_wb_req),
    .wb_rsp_i     (host_wb_rsp)
  );

  periph_link peripheral_link (
    .periphl_clk_i(periphl_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (host_wb_req),
    .wb_rsp_o     (host_wb_rsp),
    .rom_req_o    (rom_wb_req),
    .rom_rsp_i    (rom_wb_rsp),
    .uart_req_o   (uart_wb_req),
    .uart_rsp_i   (uart_wb_rsp)
  );

  // Targets
  boot_rom #(
    .ROM_WORDS(ROM_WORDS)
  ) soc_rom (
    .periphl_clk_i(periphl_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (rom_wb_req),
    .wb_rsp_o     (rom_wb_rsp)
  );

  uart_tx #(
    .DIV_RESET(DIV_RESET)
  ) uart_device (
    .periphl_clk_i(periphl_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (uart_wb_req),
    .wb_rsp_o     (uart_wb_rsp),
    .uart_tx_o    (uart_tx_o)
  );

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned DIV_RESET = 16
) (
  input  logic                    periphl_clk_i,
  input  logic                    arst_n_i,
  input  dhs_periph_pkg::wb_req_t wb_req_i,
  output dhs_periph_pkg::wb_rsp_t wb_rsp_o,
  output logic                    uart_tx_o
);

  import dhs_periph_pkg::*;

  uart_state_e state_q;
  div_t        div_q;
  div_t        div_cnt_q;
  logic [2:0]  bit_cnt_q;
  uart_byte_t  shift_q;

  logic        busy;
  logic        bit_end;
  logic        tx_load;
  logic [3:0]  ofs;
  logic        req_new;
  logic        ack_q;
  logic        err_q;
  data_t       dat_q;

  assign busy    = (state_q != TX_IDLE);
  // Region is 16-byte aligned
  assign ofs     = wb_req_i.adr[3:0];
  assign req_new = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign tx_load = req_new && wb_req_i.we && (ofs == UART_TXDATA_OFS) && !busy;
  // A divisor of zero behaves as one
  assign bit_end = ({1'b0, div_cnt_q} + 17'd1) >= {1'b0, div_q};

  ////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      div_q <= div_t'(DIV_RESET);
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (req_new) begin
        case (ofs)
          // Data write waits here until the shifter is idle
          UART_TXDATA_OFS: ack_q <= !wb_req_i.we || !busy;
          UART_STATUS_OFS: ack_q <= 1'b1;
          UART_DIV_OFS: begin
            ack_q <= 1'b1;
            if (wb_req_i.we && wb_req_i.sel[0]) div_q[7:0] <= wb_req_i.dat[7:0];
            if (wb_req_i.we && wb_req_i.sel[1]) div_q[15:8] <= wb_req_i.dat[15:8];
          end
          default: err_q <= 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (req_new) begin
      case (ofs)
        UART_STATUS_OFS: dat_q <= data_t'(busy);
        UART_DIV_OFS:    dat_q <= data_t'(div_q);
        default:         dat_q <= '0;
      endcase
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

  ////////////////////////////////////////////////////////////
  // Transmit shifter, 8N1
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= TX_IDLE;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      if (state_q == TX_IDLE || bit_end) begin
        div_cnt_q <= '0;
      end else begin
        div_cnt_q <= div_cnt_q + 16'd1;
      end
      case (state_q)
        TX_IDLE: if (tx_load) state_q <= TX_START;
        TX_START: begin
          if (bit_end) begin
            state_q   <= TX_DATA;
            bit_cnt_q <= '0;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) state_q <= TX_STOP;
          end
        end
        TX_STOP: if (bit_end) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge periphl_clk_i) begin
    if (tx_load) begin
      shift_q <= wb_req_i.dat[7:0];
    end else if (state_q == TX_DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_comb begin
    case (state_q)
      TX_START: uart_tx_o = 1'b0;
      TX_DATA:  uart_tx_o = shift_q[0];
      default:  uart_tx_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom #(
  parameter int unsigned ROM_WORDS = 64
) (
  input  logic                    periphl_clk_i,
  input  logic                    arst_n_i,
  input  dhs_periph_pkg::wb_req_t wb_req_i,
  output dhs_periph_pkg::wb_rsp_t wb_rsp_o
);

  import dhs_periph_pkg::*;

  // Word index width over the whole region
  localparam int unsigned IDXW = $clog2(BOOT_ROM_SIZE) - 2;

  addr_t           rom_ofs;
  logic [IDXW-1:0] word_idx;
  data_t           rom_word;
  logic            req_new;
  logic            ack_q;
  logic            err_q;
  data_t           dat_q;

  assign rom_ofs  = wb_req_i.adr - BOOT_ROM_BASE;
  assign word_idx = rom_ofs[IDXW+1:2];
  assign req_new  = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;

  always_comb begin
    rom_word = '0;
    if (32'(word_idx) < ROM_WORDS) begin
      case (word_idx)
        `include "boot_rom_table.svh"
        default: rom_word = '0;
      endcase
    end
  end

  // Writes are refused
  always_ff @(posedge periphl_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_new && !wb_req_i.we;
      err_q <= req_new && wb_req_i.we;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (req_new) begin
      dat_q <= wb_req_i.we ? '0 : rom_word;
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

`default_nettype wire

//--- logic/periph_link.sv
`timescale 1ns/1ps
`default_nettype none

module periph_link (
  input  logic                    periphl_clk_i,
  input  logic                    arst_n_i,
  input  dhs_periph_pkg::wb_req_t wb_req_i,
  output dhs_periph_pkg::wb_rsp_t wb_rsp_o,
  output dhs_periph_pkg::wb_req_t rom_req_o,
  input  dhs_periph_pkg::wb_rsp_t rom_rsp_i,
  output dhs_periph_pkg::wb_req_t uart_req_o,
  input  dhs_periph_pkg::wb_rsp_t uart_rsp_i
);

  import dhs_periph_pkg::*;

  addr_t rom_ofs;
  addr_t uart_ofs;
  logic  rom_hit;
  logic  uart_hit;
  logic  no_hit;
  logic  miss_err_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Offsets wrap below the base, so one compare covers both ends
  assign rom_ofs  = wb_req_i.adr - BOOT_ROM_BASE;
  assign uart_ofs = wb_req_i.adr - UART_BASE;
  assign rom_hit  = rom_ofs < BOOT_ROM_SIZE;
  assign uart_hit = uart_ofs < UART_SIZE;
  assign no_hit   = !rom_hit && !uart_hit;

  always_comb begin
    rom_req_o      = wb_req_i;
    rom_req_o.stb  = wb_req_i.stb && rom_hit;
    uart_req_o     = wb_req_i;
    uart_req_o.stb = wb_req_i.stb && uart_hit;
  end

  ////////////////////////////////////////////////////////////
  // Default error target
  ////////////////////////////////////////////////////////////

  // One err per stb, even though stb is still up in the err cycle
  always_ff @(posedge periphl_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      miss_err_q <= 1'b0;
    end else begin
      miss_err_q <= wb_req_i.cyc && wb_req_i.stb && no_hit && !miss_err_q;
    end
  end

  // Response mux, select held steady by the master's address
  always_comb begin
    if (rom_hit) begin
      wb_rsp_o = rom_rsp_i;
    end else if (uart_hit) begin
      wb_rsp_o = uart_rsp_i;
    end else begin
      wb_rsp_o     = '0;
      wb_rsp_o.err = miss_err_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/apb_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module apb_wb_bridge (
  input  logic                     periphl_clk_i,
  input  logic                     arst_n_i,
  input  dhs_periph_pkg::apb_req_t apb_req_i,
  output dhs_periph_pkg::apb_rsp_t apb_rsp_o,
  output dhs_periph_pkg::wb_req_t  wb_req_o,
  input  dhs_periph_pkg::wb_rsp_t  wb_rsp_i
);

  import dhs_periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;

  // Held Wishbone request
  addr_t adr_q;
  logic  we_q;
  data_t wdat_q;
  strb_t sel_q;

  // Captured response
  data_t rdat_q;
  logic  err_q;

  logic  apb_access;
  logic  wb_done;

  // First access cycle of an APB transfer
  assign apb_access = apb_req_i.psel && apb_req_i.penable;
  assign wb_done    = wb_rsp_i.ack || wb_rsp_i.err;

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: if (apb_access) state_d = BR_BUS;
      BR_BUS:  if (wb_done) state_d = BR_DONE;
      BR_DONE: state_d = BR_IDLE;
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge periphl_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (state_q == BR_IDLE && apb_access) begin
      adr_q  <= apb_req_i.paddr;
      we_q   <= apb_req_i.pwrite;
      wdat_q <= apb_req_i.pwdata;
      // Reads take all byte lanes
      sel_q  <= apb_req_i.pwrite ? apb_req_i.pstrb : '1;
    end
    if (state_q == BR_BUS && wb_done) begin
      rdat_q <= wb_rsp_i.dat;
      err_q  <= wb_rsp_i.err;
    end
  end

  // stb drops in the cycle after ack or err
  assign wb_req_o = '{cyc: (state_q == BR_BUS), stb: (state_q == BR_BUS),
                      we: we_q, adr: adr_q, dat: wdat_q, sel: sel_q};

  assign apb_rsp_o = '{pready: (state_q == BR_DONE), prdata: rdat_q, pslverr: err_q};

endmodule

`default_nettype wire

//--- logic/dhs_periph_pkg.sv
`default_nettype none

package dhs_periph_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DHS_ADDRW = 32;
  localparam int unsigned DHS_DATAW = 32;
  localparam int unsigned DHS_STRBW = DHS_DATAW / 8;

  typedef logic [DHS_ADDRW-1:0] addr_t;
  typedef logic [DHS_DATAW-1:0] data_t;
  typedef logic [DHS_STRBW-1:0] strb_t;

  // Baud divisor, in peripheral clock cycles per bit
  typedef logic [15:0] div_t;
  typedef logic [7:0]  uart_byte_t;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  localparam addr_t BOOT_ROM_BASE = 32'h0000_0000;
  localparam addr_t BOOT_ROM_SIZE = 32'h0000_0100;
  localparam addr_t UART_BASE     = 32'h0000_1000;
  localparam addr_t UART_SIZE     = 32'h0000_0010;

  // UART register offsets within its region
  localparam logic [3:0] UART_TXDATA_OFS = 4'h0;
  localparam logic [3:0] UART_STATUS_OFS = 4'h4;
  localparam logic [3:0] UART_DIV_OFS    = 4'h8;

  ////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  // Wishbone classic, one outstanding cycle
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    strb_t sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // FSM states
  typedef enum logic [1:0] {BR_IDLE, BR_BUS, BR_DONE} bridge_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_state_e;

endpackage

`default_nettype wire

//--- include/boot_rom_table.svh
`ifndef BOOT_ROM_TABLE_SVH
`define BOOT_ROM_TABLE_SVH

// Boot stub, one case item per word
// Set up gp and sp, then send 'A' on the UART and spin
6'd0: rom_word = 32'h0000_1197;
6'd1: rom_word = 32'h8001_8193;
6'd2: rom_word = 32'h0000_2117;
6'd3: rom_word = 32'hff81_0113;
6'd4: rom_word = 32'h0000_12b7;
6'd5: rom_word = 32'h0410_0313;
6'd6: rom_word = 32'h0062_a023;
6'd7: rom_word = 32'h0000_006f;
// Image tag and version
6'd8: rom_word = 32'h4448_5342;
6'd9: rom_word = 32'h0000_0001;

`endif
